/* files.f */
source/uart_pkg.sv
source/uart_baud_nco.sv
source/uart_byte_fifo.sv
source/uart_tx.sv
source/uart_rx_filter.sv
source/uart_rx.sv
source/uart_top.sv
sim/tb_clock_gen.sv
sim/uart_checker.sv
sim/tb_uart.sv

/* sim/tb_uart.sv */
////////////////////////////////////////
// uart testbench top, random traffic
// through tx, rx, errors and loopback
////////////////////////////////////////
`default_nettype none
`timescale 1ns/100ps

module tb_uart;

  import uart_pkg::*;

  localparam nco_incr_t NcoIncr = nco_incr_t'(4096);
  localparam int BitCycles  = 256;
  localparam int TxPerMode  = 4;
  localparam int RxFrames   = 8;
  localparam int NfFrames   = 8;
  localparam int ErrFrames  = 3;
  localparam int OvfFrames  = 6;
  localparam int LoopFrames = 6;
  localparam int NumFrames  = 3 * TxPerMode + RxFrames + NfFrames + ErrFrames
                              + 2 * OvfFrames + LoopFrames;
  localparam int MaxCycles  = NumFrames * 12 * BitCycles * 2;

  logic         clk;
  logic         rst_n;
  uart_cfg_t    cfg;
  logic         tx_valid;
  uart_data_t   tx_data;
  logic         tx_ready;
  logic         rx_valid;
  uart_data_t   rx_data;
  logic         rx_ready;
  logic         rx_line;
  logic         tx_line;
  uart_status_t status;
  uart_rx_err_t rx_err;

  integer     seed       = 32'h2bc64f08;
  integer     ready_seed = 32'h2bc64f08;
  int         cycle_cnt  = 0;
  logic       timed_out  = 1'b0;
  logic       rx_hold;
  uart_data_t d;
  int         i;
  int         m;

  tb_clock_gen u_clock_gen (
    .clk_o  (clk),
    .rst_no (rst_n)
  );

  uart_top u_uart_top (
    .clk_i      (clk),
    .rst_ni     (rst_n),
    .cfg_i      (cfg),
    .tx_valid_i (tx_valid),
    .tx_data_i  (tx_data),
    .tx_ready_o (tx_ready),
    .rx_valid_o (rx_valid),
    .rx_data_o  (rx_data),
    .rx_ready_i (rx_ready),
    .rx_i       (rx_line),
    .tx_o       (tx_line),
    .status_o   (status),
    .rx_err_o   (rx_err)
  );

  uart_checker u_checker (
    .clk_i      (clk),
    .rst_ni     (rst_n),
    .cfg_i      (cfg),
    .tx_valid_i (tx_valid),
    .tx_data_i  (tx_data),
    .tx_ready_i (tx_ready),
    .rx_valid_i (rx_valid),
    .rx_data_i  (rx_data),
    .rx_ready_i (rx_ready),
    .tx_line_i  (tx_line),
    .status_i   (status),
    .rx_err_i   (rx_err)
  );

  task automatic set_mode(input logic par_en, input logic par_odd, input logic nf,
                          input logic loop);
    @(negedge clk);
    cfg.parity_en    = par_en;
    cfg.parity_odd   = par_odd;
    cfg.nf_en        = nf;
    cfg.sys_loopback = loop;
  endtask

  // valid stays up until a rising edge with ready high
  task automatic send_byte(input uart_data_t b);
    logic taken;
    tx_valid = 1'b1;
    tx_data  = b;
    taken    = 1'b0;
    while (!taken) begin
      taken = tx_ready;
      @(negedge clk);
    end
    tx_valid = 1'b0;
  endtask

  // start, data lsb first, optional parity, stop
  task automatic send_frame(input uart_data_t b, input logic bad_par, input logic bad_stop,
                            input logic glitch);
    logic [10:0] bits;
    int          nbits;
    int          k;
    int          g;
    bits      = '1;
    bits[0]   = 1'b0;
    bits[8:1] = b;
    if (cfg.parity_en) begin
      bits[9] = (^b) ^ cfg.parity_odd ^ bad_par;
    end
    nbits           = cfg.parity_en ? 11 : 10;
    bits[nbits - 1] = ~bad_stop;
    for (k = 0; k < nbits; k++) begin
      rx_line = bits[k];
      if (glitch && k >= 1 && k <= 8) begin
        g = 100 + ($random(seed) & 63);
        repeat (g) @(negedge clk);
        rx_line = ~bits[k];
        @(negedge clk);
        rx_line = bits[k];
        repeat (BitCycles - 1 - g) @(negedge clk);
      end else begin
        repeat (BitCycles) @(negedge clk);
      end
    end
    rx_line = 1'b1;
    repeat (4 + ($random(seed) & 15) + (bad_stop ? BitCycles : 0)) @(negedge clk);
  endtask

  task automatic wait_idle();
    while (u_checker.pending() != 0 || !status.tx_idle || !status.rx_idle ||
           status.rx_level != '0) begin
      @(negedge clk);
    end
    repeat (16) @(negedge clk);
  endtask

  task finish_run();
    int errs;
    errs = u_checker.err_cnt + int'(timed_out);
    $display("checks: %0d, errors: %0d", u_checker.chk_cnt, errs);
    if (errs == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  endtask

  // host read side, random ready unless held off
  always @(negedge clk) begin
    rx_ready = rx_hold ? 1'b0 : (($random(ready_seed) & 3) != 0);
  end

  always @(posedge clk) begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt == MaxCycles) begin
      $display("timeout: traffic did not complete within %0d cycles", MaxCycles);
      timed_out = 1'b1;
      finish_run();
    end
  end

  initial begin
    cfg       = '0;
    cfg.tx_en = 1'b1;
    cfg.rx_en = 1'b1;
    cfg.nco   = NcoIncr;
    tx_valid  = 1'b0;
    tx_data   = '0;
    rx_line   = 1'b1;
    rx_ready  = 1'b0;
    rx_hold   = 1'b1;

    repeat (4) @(negedge clk);
    u_checker.check_reset_state();
    @(posedge rst_n);
    @(negedge clk);
    rx_hold = 1'b0;

    // tx frames without parity, then even, then odd
    for (m = 0; m < 3; m++) begin
      set_mode(m > 0, m == 2, 1'b0, 1'b0);
      for (i = 0; i < TxPerMode; i++) begin
        send_byte(uart_data_t'($random(seed)));
      end
      wait_idle();
    end
    u_checker.check_err_counts(0, 0, 0);

    // rx frames, raw input path
    set_mode(1'b0, 1'b0, 1'b0, 1'b0);
    for (i = 0; i < RxFrames; i++) begin
      d = uart_data_t'($random(seed));
      u_checker.expect_rx(d);
      send_frame(d, 1'b0, 1'b0, 1'b0);
    end
    wait_idle();
    u_checker.check_err_counts(0, 0, 0);

    // glitched data bits with the majority filter on
    set_mode(1'b1, 1'b0, 1'b1, 1'b0);
    for (i = 0; i < NfFrames; i++) begin
      d = uart_data_t'($random(seed));
      u_checker.expect_rx(d);
      send_frame(d, 1'b0, 1'b0, 1'b1);
    end
    wait_idle();
    u_checker.check_err_counts(0, 0, 0);

    // bad parity, bad stop, then a good frame
    set_mode(1'b1, 1'b0, 1'b0, 1'b0);
    send_frame(uart_data_t'($random(seed)), 1'b1, 1'b0, 1'b0);
    send_frame(uart_data_t'($random(seed)), 1'b0, 1'b1, 1'b0);
    d = uart_data_t'($random(seed));
    u_checker.expect_rx(d);
    send_frame(d, 1'b0, 1'b0, 1'b0);
    wait_idle();
    u_checker.check_err_counts(1, 1, 0);

    // rx fifo overflow with the host not reading
    set_mode(1'b0, 1'b0, 1'b0, 1'b0);
    rx_hold = 1'b1;
    for (i = 0; i < OvfFrames; i++) begin
      d = uart_data_t'($random(seed));
      if (i < FifoDepth) begin
        u_checker.expect_rx(d);
      end
      send_frame(d, 1'b0, 1'b0, 1'b0);
    end
    u_checker.check_err_counts(1, 1, OvfFrames - FifoDepth);
    u_checker.check_value("rx fifo level when full", status.rx_level, FifoDepth);
    rx_hold = 1'b0;
    wait_idle();

    // tx back-pressure, fifo plus serializer
    for (i = 0; i < OvfFrames; i++) begin
      send_byte(uart_data_t'($random(seed)));
    end
    u_checker.check_value("tx_ready_o low while full", u_checker.stall_cnt > 0, 1);
    wait_idle();

    // system loopback with odd parity
    set_mode(1'b1, 1'b1, 1'b0, 1'b1);
    for (i = 0; i < LoopFrames; i++) begin
      send_byte(uart_data_t'($random(seed)));
    end
    wait_idle();
    set_mode(1'b0, 1'b0, 1'b0, 1'b0);
    u_checker.check_err_counts(1, 1, OvfFrames - FifoDepth);

    finish_run();
  end

endmodule

`default_nettype wire

/* sim/uart_checker.sv */
////////////////////////////////////////
// uart checker, host handshakes, tx line
// decoder and error pulse counters
////////////////////////////////////////
`default_nettype none
`timescale 1ns/100ps

module uart_checker (
  input wire logic                  clk_i,
  input wire logic                  rst_ni,
  input wire uart_pkg::uart_cfg_t   cfg_i,
  input wire logic                  tx_valid_i,
  input wire uart_pkg::uart_data_t  tx_data_i,
  input wire logic                  tx_ready_i,
  input wire logic                  rx_valid_i,
  input wire uart_pkg::uart_data_t  rx_data_i,
  input wire logic                  rx_ready_i,
  input wire logic                  tx_line_i,
  input wire uart_pkg::uart_status_t status_i,
  input wire uart_pkg::uart_rx_err_t rx_err_i
);

  import uart_pkg::*;

  uart_data_t  exp_rx [$];
  uart_data_t  exp_tx [$];
  uart_data_t  rx_exp;
  uart_data_t  tx_exp;
  logic [10:0] line_bits;
  int          err_cnt   = 0;
  int          chk_cnt   = 0;
  int          ferr_cnt  = 0;
  int          perr_cnt  = 0;
  int          ovf_cnt   = 0;
  int          stall_cnt = 0;

  task automatic flag_error(input string msg);
    err_cnt++;
    $display("[FAIL] %0t: %s", $time, msg);
  endtask

  task automatic check_value(input string what, input int got, input int exp);
    chk_cnt++;
    if (got != exp) begin
      flag_error($sformatf("%s: got %0h, expected %0h", what, got, exp));
    end
  endtask

  task automatic expect_rx(input uart_data_t d);
    exp_rx.push_back(d);
  endtask

  function automatic int pending();
    return exp_rx.size() + exp_tx.size();
  endfunction

  // ones over the data bits and the parity bit
  function automatic int count_ones(input logic [8:0] v);
    int n;
    int j;
    n = 0;
    for (j = 0; j < 9; j++) begin
      n += v[j];
    end
    return n;
  endfunction

  // cumulative pulse counts since reset
  task automatic check_err_counts(input int frame, input int parity, input int overflow);
    check_value("frame_err pulses", ferr_cnt, frame);
    check_value("parity_err pulses", perr_cnt, parity);
    check_value("overflow pulses", ovf_cnt, overflow);
  endtask

  task automatic check_reset_state();
    check_value("tx_o in reset", tx_line_i, 1);
    check_value("rx_valid_o in reset", rx_valid_i, 0);
    check_value("tx_ready_o in reset", tx_ready_i, 1);
    check_value("rx_err_o in reset", rx_err_i, 0);
    check_value("tx_idle in reset", status_i.tx_idle, 1);
    check_value("rx_idle in reset", status_i.rx_idle, 1);
  endtask

  ////////////////////////////////////////
  // host side
  ////////////////////////////////////////

  // accepted tx bytes come back on rx in system loopback
  always @(posedge clk_i) begin
    if (rst_ni && tx_valid_i && tx_ready_i) begin
      if (cfg_i.sys_loopback) begin
        exp_rx.push_back(tx_data_i);
      end else begin
        exp_tx.push_back(tx_data_i);
      end
    end
    if (rst_ni && tx_valid_i && !tx_ready_i) begin
      stall_cnt++;
      check_value("tx_level while stalled", status_i.tx_level, FifoDepth);
    end
  end

  always @(posedge clk_i) begin
    if (rst_ni && rx_valid_i && rx_ready_i) begin
      if (exp_rx.size() == 0) begin
        flag_error($sformatf("unexpected byte %02h on rx_data_o", rx_data_i));
      end else begin
        rx_exp = exp_rx.pop_front();
        check_value("rx_data_o", rx_data_i, rx_exp);
      end
    end
  end

  always @(posedge clk_i) begin
    if (rst_ni) begin
      ferr_cnt += rx_err_i.frame_err;
      perr_cnt += rx_err_i.parity_err;
      ovf_cnt  += rx_err_i.overflow;
      if (cfg_i.sys_loopback && tx_line_i !== 1'b1) begin
        flag_error("tx_o left the idle level during system loopback");
      end
    end
  end

  ////////////////////////////////////////
  // tx line decoder
  ////////////////////////////////////////

  // offset 0 is the first edge that sees the start bit,
  // each bit is sampled near both ends and in the middle
  task decode_frame();
    int   nbits;
    int   k;
    logic early;
    logic mid;
    logic late;
    nbits     = cfg_i.parity_en ? 11 : 10;
    line_bits = '1;
    for (k = 0; k < nbits; k++) begin
      repeat ((k == 0) ? 2 : 5) @(posedge clk_i);
      early = tx_line_i;
      repeat (126) @(posedge clk_i);
      mid = tx_line_i;
      repeat (125) @(posedge clk_i);
      late = tx_line_i;
      chk_cnt++;
      if (early !== mid || late !== mid) begin
        flag_error($sformatf("tx bit %0d not held for 256 +/- 2 cycles", k));
      end
      line_bits[k] = mid;
    end
    if (exp_tx.size() == 0) begin
      flag_error($sformatf("unexpected frame %02h on tx_o", line_bits[8:1]));
    end else begin
      tx_exp = exp_tx.pop_front();
      check_value("tx start bit", line_bits[0], 0);
      check_value("tx data", line_bits[8:1], tx_exp);
      // even parity keeps the count of ones even, odd parity keeps it odd
      if (cfg_i.parity_en) begin
        check_value("tx parity bit", count_ones(line_bits[9:1]) % 2, cfg_i.parity_odd);
      end
      check_value("tx stop bit", line_bits[nbits-1], 1);
    end
  endtask

  always begin
    @(posedge clk_i);
    if (rst_ni && !cfg_i.sys_loopback && tx_line_i === 1'b0) begin
      decode_frame();
    end
  end

endmodule

`default_nettype wire

/* sim/tb_clock_gen.sv */
////////////////////////////////////////
// testbench clock and reset generator
////////////////////////////////////////
`default_nettype none
`timescale 1ns/100ps

module tb_clock_gen (
  output logic clk_o,
  output logic rst_no
);

  localparam int ClkPeriod   = 10;
  localparam int ResetCycles = 8;

  initial begin
    clk_o = 1'b0;
    forever #(ClkPeriod / 2) clk_o = ~clk_o;
  end

  // release away from the rising edge
  initial begin
    rst_no = 1'b0;
    repeat (ResetCycles) @(posedge clk_o);
    @(negedge clk_o);
    rst_no = 1'b1;
  end

endmodule

`default_nettype wire

/* source/uart_top.sv */
////////////////////////////////////////
// uart top, nco, fifos and both paths
////////////////////////////////////////
`default_nettype none
`timescale 1ns/100ps

module uart_top (
  input  wire logic                  clk_i,
  input  wire logic                  rst_ni,
  input  wire uart_pkg::uart_cfg_t   cfg_i,
  input  wire logic                  tx_valid_i,
  input  wire uart_pkg::uart_data_t  tx_data_i,
  output logic                       tx_ready_o,
  output logic                       rx_valid_o,
  output uart_pkg::uart_data_t       rx_data_o,
  input  wire logic                  rx_ready_i,
  input  wire logic                  rx_i,
  output logic                       tx_o,
  output uart_pkg::uart_status_t     status_o,
  output uart_pkg::uart_rx_err_t     rx_err_o
);

  import uart_pkg::*;

  logic        tick;
  uart_data_t  tx_fifo_rdata;
  logic        tx_fifo_rvalid;
  logic        tx_fifo_rready;
  fifo_level_t tx_level;
  logic        tx_wvalid;
  logic        tx_wready;
  logic        tx_parity;
  logic        tx_idle;
  logic        tx_ser;
  logic        tx_q;
  logic        rx_line;
  logic        rx_valid;
  uart_data_t  rx_data;
  logic        rx_frame_err;
  logic        rx_parity_err;
  logic        rx_idle;
  logic        rx_fifo_wvalid;
  logic        rx_fifo_wready;
  fifo_level_t rx_level;

  uart_baud_nco u_baud_nco (
    .clk_i,
    .rst_ni,
    .en_i   (cfg_i.tx_en | cfg_i.rx_en),
    .incr_i (cfg_i.nco),
    .tick_o (tick)
  );

  ////////////////////////////////////////
  // transmit
  ////////////////////////////////////////

  uart_byte_fifo u_tx_fifo (
    .clk_i,
    .rst_ni,
    .wvalid_i (tx_valid_i),
    .wready_o (tx_ready_o),
    .wdata_i  (tx_data_i),
    .rvalid_o (tx_fifo_rvalid),
    .rready_i (tx_fifo_rready),
    .rdata_o  (tx_fifo_rdata),
    .level_o  (tx_level)
  );

  // serializer only takes bytes while transmit is enabled
  assign tx_wvalid      = tx_fifo_rvalid & cfg_i.tx_en;
  assign tx_fifo_rready = tx_wready & cfg_i.tx_en;
  assign tx_parity      = (^tx_fifo_rdata) ^ cfg_i.parity_odd;

  uart_tx u_tx (
    .clk_i,
    .rst_ni,
    .tick_i      (tick),
    .parity_en_i (cfg_i.parity_en),
    .wvalid_i    (tx_wvalid),
    .wready_o    (tx_wready),
    .wdata_i     (tx_fifo_rdata),
    .parity_i    (tx_parity),
    .idle_o      (tx_idle),
    .tx_o        (tx_ser)
  );

  // line held idle while looped back internally
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      tx_q <= 1'b1;
    end else begin
      tx_q <= cfg_i.sys_loopback ? 1'b1 : tx_ser;
    end
  end

  assign tx_o = tx_q;

  ////////////////////////////////////////
  // receive
  ////////////////////////////////////////

  uart_rx_filter u_rx_filter (
    .clk_i,
    .rst_ni,
    .rx_i           (rx_i),
    .loop_tx_i      (tx_ser),
    .nf_en_i        (cfg_i.nf_en),
    .sys_loopback_i (cfg_i.sys_loopback),
    .rx_o           (rx_line)
  );

  uart_rx u_rx (
    .clk_i,
    .rst_ni,
    .en_i         (cfg_i.rx_en),
    .tick_i       (tick),
    .rx_i         (rx_line),
    .parity_en_i  (cfg_i.parity_en),
    .parity_odd_i (cfg_i.parity_odd),
    .valid_o      (rx_valid),
    .data_o       (rx_data),
    .frame_err_o  (rx_frame_err),
    .parity_err_o (rx_parity_err),
    .idle_o       (rx_idle)
  );

  // errored bytes never reach the fifo
  assign rx_fifo_wvalid = rx_valid & ~rx_frame_err & ~rx_parity_err;

  uart_byte_fifo u_rx_fifo (
    .clk_i,
    .rst_ni,
    .wvalid_i (rx_fifo_wvalid),
    .wready_o (rx_fifo_wready),
    .wdata_i  (rx_data),
    .rvalid_o (rx_valid_o),
    .rready_i (rx_ready_i),
    .rdata_o  (rx_data_o),
    .level_o  (rx_level)
  );

  // status and event pulses
  assign rx_err_o.frame_err  = rx_frame_err;
  assign rx_err_o.parity_err = rx_parity_err;
  assign rx_err_o.overflow   = rx_fifo_wvalid & ~rx_fifo_wready;

  assign status_o.tx_idle  = tx_idle & ~tx_fifo_rvalid;
  assign status_o.rx_idle  = rx_idle;
  assign status_o.tx_level = tx_level;
  assign status_o.rx_level = rx_level;

endmodule

`default_nettype wire

/* source/uart_rx.sv */
////////////////////////////////////////
// receive fsm, mid-bit sampling with
// parity and stop bit checks
////////////////////////////////////////
`default_nettype none
`timescale 1ns/100ps

module uart_rx (
  input  wire logic              clk_i,
  input  wire logic              rst_ni,
  input  wire logic              en_i,
  input  wire logic              tick_i,
  input  wire logic              rx_i,
  input  wire logic              parity_en_i,
  input  wire logic              parity_odd_i,
  output logic                   valid_o,
  output uart_pkg::uart_data_t   data_o,
  output logic                   frame_err_o,
  output logic                   parity_err_o,
  output logic                   idle_o
);

  import uart_pkg::*;

  rx_state_e  state_q;
  tick_cnt_t  tick_cnt_q;
  bit_cnt_t   bit_cnt_q;
  uart_data_t data_q;
  logic       parity_q;
  logic       valid_q;
  logic       frame_err_q;
  logic       parity_err_q;
  logic       mid_bit;

  // tick counter is 4 bits wide and wraps to 0 after each full bit
  assign mid_bit = tick_i & (tick_cnt_q == tick_cnt_t'(OversampleRate - 1));

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q      <= RX_IDLE;
      tick_cnt_q   <= '0;
      bit_cnt_q    <= '0;
      valid_q      <= 1'b0;
      frame_err_q  <= 1'b0;
      parity_err_q <= 1'b0;
    end else begin
      valid_q      <= 1'b0;
      frame_err_q  <= 1'b0;
      parity_err_q <= 1'b0;
      if (tick_i) begin
        tick_cnt_q <= tick_cnt_q + 1'b1;
      end
      if (!en_i) begin
        state_q <= RX_IDLE;
      end else begin
        unique case (state_q)
          RX_IDLE: begin
            if (tick_i && !rx_i) begin
              state_q    <= RX_START;
              tick_cnt_q <= '0;
            end
          end
          // recheck at the middle of the start bit
          RX_START: begin
            if (tick_i && tick_cnt_q == tick_cnt_t'(OversampleRate / 2 - 1)) begin
              tick_cnt_q <= '0;
              bit_cnt_q  <= '0;
              state_q    <= rx_i ? RX_IDLE : RX_DATA;
            end
          end
          RX_DATA: begin
            if (mid_bit) begin
              bit_cnt_q <= bit_cnt_q + 1'b1;
              if (bit_cnt_q == bit_cnt_t'(7)) begin
                state_q <= parity_en_i ? RX_PARITY : RX_STOP;
              end
            end
          end
          RX_PARITY: begin
            if (mid_bit) begin
              state_q <= RX_STOP;
            end
          end
          RX_STOP: begin
            if (mid_bit) begin
              valid_q      <= 1'b1;
              frame_err_q  <= ~rx_i;
              parity_err_q <= parity_en_i & (^data_q ^ parity_q ^ parity_odd_i);
              state_q      <= RX_IDLE;
            end
          end
          default: state_q <= RX_IDLE;
        endcase
      end
    end
  end

  // data arrives lsb first
  always_ff @(posedge clk_i) begin
    if (en_i && mid_bit && state_q == RX_DATA) begin
      data_q <= {rx_i, data_q[7:1]};
    end
    if (en_i && mid_bit && state_q == RX_PARITY) begin
      parity_q <= rx_i;
    end
  end

  assign valid_o      = valid_q;
  assign data_o       = data_q;
  assign frame_err_o  = frame_err_q;
  assign parity_err_o = parity_err_q;
  assign idle_o       = (state_q == RX_IDLE);

endmodule

`default_nettype wire

/* source/uart_rx_filter.sv */
////////////////////////////////////////
// rx synchronizer, majority filter and
// system loopback select
////////////////////////////////////////
`default_nettype none
`timescale 1ns/100ps

module uart_rx_filter (
  input  wire logic clk_i,
  input  wire logic rst_ni,
  input  wire logic rx_i,
  input  wire logic loop_tx_i,
  input  wire logic nf_en_i,
  input  wire logic sys_loopback_i,
  output logic      rx_o
);

  logic [1:0] sync_q;
  logic [1:0] hist_q;
  logic       rx_sync;
  logic       rx_maj;

  // line idles high, so everything resets to 1
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      sync_q <= 2'b11;
      hist_q <= 2'b11;
    end else begin
      sync_q <= {sync_q[0], rx_i};
      hist_q <= {hist_q[0], rx_sync};
    end
  end

  assign rx_sync = sync_q[1];

  // 2 of 3 vote masks single-cycle glitches
  assign rx_maj = (rx_sync & hist_q[0]) | (rx_sync & hist_q[1]) | (hist_q[0] & hist_q[1]);

  assign rx_o = sys_loopback_i ? loop_tx_i : (nf_en_i ? rx_maj : rx_sync);

endmodule

`default_nettype wire

/* source/uart_tx.sv */
////////////////////////////////////////
// transmit serializer, 8 data bits with
// optional parity and one stop bit
////////////////////////////////////////
`default_nettype none
`timescale 1ns/100ps

module uart_tx (
  input  wire logic                  clk_i,
  input  wire logic                  rst_ni,
  input  wire logic                  tick_i,
  input  wire logic                  parity_en_i,
  input  wire logic                  wvalid_i,
  output logic                       wready_o,
  input  wire uart_pkg::uart_data_t  wdata_i,
  input  wire logic                  parity_i,
  output logic                       idle_o,
  output logic                       tx_o
);

  import uart_pkg::*;

  // frame is stop, parity, data, start with bit 0 sent first
  logic [10:0] sreg_q;
  bit_cnt_t    bit_cnt_q;
  tick_cnt_t   tick_cnt_q;
  logic        tx_q;
  logic        idle;
  logic        load;
  logic        shift;

  assign idle     = (bit_cnt_q == '0);
  assign load     = wvalid_i & idle;
  assign shift    = tick_i & ~idle & (tick_cnt_q == tick_cnt_t'(OversampleRate - 1));
  assign wready_o = idle;
  assign idle_o   = idle;
  assign tx_o     = tx_q;

  always_ff @(posedge clk_i) begin
    if (load) begin
      sreg_q <= {1'b1, parity_en_i ? parity_i : 1'b1, wdata_i, 1'b0};
    end else if (shift) begin
      sreg_q <= {1'b1, sreg_q[10:1]};
    end
  end

  // tick counter preloaded so the start bit lines up with the next tick
  // one extra shift at the end times out the stop bit
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      bit_cnt_q  <= '0;
      tick_cnt_q <= '0;
      tx_q       <= 1'b1;
    end else if (load) begin
      bit_cnt_q  <= parity_en_i ? bit_cnt_t'(12) : bit_cnt_t'(11);
      tick_cnt_q <= tick_cnt_t'(OversampleRate - 1);
    end else if (!idle && tick_i) begin
      tick_cnt_q <= tick_cnt_q + 1'b1;
      if (shift) begin
        tx_q      <= sreg_q[0];
        bit_cnt_q <= bit_cnt_q - 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

/* source/uart_byte_fifo.sv */
////////////////////////////////////////
// synchronous byte fifo, valid/ready
////////////////////////////////////////
`default_nettype none
`timescale 1ns/100ps

module uart_byte_fifo (
  input  wire logic                  clk_i,
  input  wire logic                  rst_ni,
  input  wire logic                  wvalid_i,
  output logic                       wready_o,
  input  wire uart_pkg::uart_data_t  wdata_i,
  output logic                       rvalid_o,
  input  wire logic                  rready_i,
  output uart_pkg::uart_data_t       rdata_o,
  output uart_pkg::fifo_level_t      level_o
);

  import uart_pkg::*;

  uart_data_t                   mem_q [FifoDepth];
  logic [$clog2(FifoDepth)-1:0] wptr_q;
  logic [$clog2(FifoDepth)-1:0] rptr_q;
  fifo_level_t                  count_q;
  logic                         do_wr;
  logic                         do_rd;

  assign wready_o = (count_q != fifo_level_t'(FifoDepth));
  assign rvalid_o = (count_q != '0);
  assign do_wr    = wvalid_i & wready_o;
  assign do_rd    = rvalid_o & rready_i;
  assign rdata_o  = mem_q[rptr_q];
  assign level_o  = count_q;

  always_ff @(posedge clk_i) begin
    if (do_wr) begin
      mem_q[wptr_q] <= wdata_i;
    end
  end

  // depth is a power of two, pointers wrap on their own
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wptr_q  <= '0;
      rptr_q  <= '0;
      count_q <= '0;
    end else begin
      if (do_wr) begin
        wptr_q <= wptr_q + 1'b1;
      end
      if (do_rd) begin
        rptr_q <= rptr_q + 1'b1;
      end
      unique case ({do_wr, do_rd})
        2'b10:   count_q <= count_q + 3'd1;
        2'b01:   count_q <= count_q - 3'd1;
        default: count_q <= count_q;
      endcase
    end
  end

endmodule

`default_nettype wire

/* source/uart_baud_nco.sv */
////////////////////////////////////////
// nco phase accumulator, 16x baud tick
////////////////////////////////////////
`default_nettype none
`timescale 1ns/100ps

module uart_baud_nco (
  input  wire logic                 clk_i,
  input  wire logic                 rst_ni,
  input  wire logic                 en_i,
  input  wire uart_pkg::nco_incr_t  incr_i,
  output logic                      tick_o
);

  import uart_pkg::*;

  // top bit holds the carry of the last add
  logic [NcoWidth:0] acc_q;

  // tick rate is f_clk * incr / 2**NcoWidth
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      acc_q <= '0;
    end else if (en_i) begin
      acc_q <= {1'b0, acc_q[NcoWidth-1:0]} + {1'b0, incr_i};
    end
  end

  assign tick_o = acc_q[NcoWidth];

endmodule

`default_nettype wire

/* source/uart_pkg.sv */
////////////////////////////////////////
// uart widths, config/status structs
// and the receive state encoding
////////////////////////////////////////
`default_nettype none

package uart_pkg;

  localparam int NcoWidth       = 16;
  localparam int FifoDepth      = 4;
  localparam int OversampleRate = 16;

  typedef logic [7:0]          uart_data_t;
  typedef logic [NcoWidth-1:0] nco_incr_t;
  typedef logic [2:0]          fifo_level_t;
  typedef logic [3:0]          bit_cnt_t;
  typedef logic [3:0]          tick_cnt_t;

  // static configuration from the host
  typedef struct packed {
    logic      tx_en;
    logic      rx_en;
    logic      parity_en;
    logic      parity_odd;
    logic      nf_en;
    logic      sys_loopback;
    nco_incr_t nco;
  } uart_cfg_t;

  typedef struct packed {
    logic        tx_idle;
    logic        rx_idle;
    fifo_level_t tx_level;
    fifo_level_t rx_level;
  } uart_status_t;

  // one-cycle event pulses
  typedef struct packed {
    logic frame_err;
    logic parity_err;
    logic overflow;
  } uart_rx_err_t;

  typedef enum logic [2:0] {
    RX_IDLE,
    RX_START,
    RX_DATA,
    RX_PARITY,
    RX_STOP
  } rx_state_e;

endpackage

`default_nettype wire
